//--- Bender.yml
package:
  name: lc3b_pipe_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/lc3b_pkg.sv
      - src/fetch_unit.sv
      - pipeline/stage_reg.sv
      - pipeline/pipe_track.sv
      - src/hazard_detection.sv
      - src/pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_pipe_ctrl.sv

//--- bench/tb_pipe_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "lc3b_defines.svh"

module tb_pipe_ctrl;

    import lc3b_pkg::*;

    localparam int num_rows  = 21;
    localparam int max_delay = 3;

    // one program row, target is a row index
    typedef struct packed {
        lc3b_opcode op;
        lc3b_nzp    nzp;
        logic       taken;
        logic [7:0] target;
    } row_t;

    // one expected data access, seq is the owner's place in retirement order
    typedef struct packed {
        int   seq;
        int   delay;
        logic write;
    } access_t;

    // row n sits at address n * pc step
    row_t prog [num_rows] = '{
        '{op_add,  3'b000, 1'b0, 8'd0},
        '{op_and,  3'b000, 1'b0, 8'd0},
        '{op_not,  3'b000, 1'b0, 8'd0},
        '{op_ldr,  3'b000, 1'b0, 8'd0},
        '{op_str,  3'b000, 1'b0, 8'd0},
        '{op_ldi,  3'b000, 1'b0, 8'd0},
        '{op_sti,  3'b000, 1'b0, 8'd0},
        '{op_br,   3'b010, 1'b0, 8'd0},
        '{op_ldb,  3'b000, 1'b0, 8'd0},
        '{op_br,   3'b111, 1'b1, 8'd13},
        '{op_add,  3'b000, 1'b0, 8'd0},
        '{op_and,  3'b000, 1'b0, 8'd0},
        '{op_not,  3'b000, 1'b0, 8'd0},
        '{op_jmp,  3'b000, 1'b0, 8'd15},
        '{op_ldr,  3'b000, 1'b0, 8'd0},
        '{op_stb,  3'b000, 1'b0, 8'd0},
        '{op_jsr,  3'b000, 1'b0, 8'd18},
        '{op_add,  3'b000, 1'b0, 8'd0},
        '{op_trap, 3'b000, 1'b0, 8'd20},
        '{op_add,  3'b000, 1'b0, 8'd0},
        '{op_lea,  3'b000, 1'b0, 8'd0}
    };

    logic       clk;
    logic       i_reset;
    logic       i_imem_resp;
    logic       i_dmem_resp;
    logic       i_br_enable;
    lc3b_opcode i_fetch_op;
    lc3b_nzp    i_fetch_nzp;
    lc3b_word   i_redirect_pc;
    lc3b_word   o_pc;
    logic       o_imem_read;
    logic       o_dmem_read;
    logic       o_dmem_write;
    logic       o_flush;
    logic       o_wb_valid;
    lc3b_opcode o_wb_op;

    int       fetch_delay [num_rows];
    int       data_delay [num_rows];
    int       retire_q [$];
    access_t  data_q [$];
    lc3b_word fetch_q [$];
    lc3b_word req_pc;
    int       fetch_wait;
    int       data_wait;
    int       retired_count;
    logic     jump_pending;

    pipe_ctrl_top i_dut (
        .clk(clk), .i_reset(i_reset), .i_imem_resp(i_imem_resp), .i_fetch_op(i_fetch_op),
        .i_fetch_nzp(i_fetch_nzp), .i_dmem_resp(i_dmem_resp), .i_br_enable(i_br_enable),
        .i_redirect_pc(i_redirect_pc), .o_pc(o_pc), .o_imem_read(o_imem_read),
        .o_dmem_read(o_dmem_read), .o_dmem_write(o_dmem_write), .o_flush(o_flush),
        .o_wb_valid(o_wb_valid), .o_wb_op(o_wb_op)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic transfers_control(input lc3b_opcode op);
        return (op == op_jmp) || (op == op_jsr) || (op == op_trap);
    endfunction

    // data responses each opcode needs in MEM
    function automatic int data_accesses(input lc3b_opcode op);
        if (op == op_ldi || op == op_sti) begin
            return 2;
        end
        if (op == op_ldr || op == op_str || op == op_ldb || op == op_stb) begin
            return 1;
        end
        return 0;
    endfunction

    // sti reads its pointer first and writes on the second access
    function automatic logic writes_data(input lc3b_opcode op, input int access_idx);
        if (op == op_sti) begin
            return access_idx == 1;
        end
        return (op == op_str) || (op == op_stb);
    endfunction

    // addresses past the program read as an add
    function automatic row_t row_at(input lc3b_word pc);
        row_t idle;
        int   idx;
        idle    = '0;
        idle.op = op_add;
        idx     = int'(pc) / `LC3B_PC_STEP;
        if (idx < num_rows) begin
            return prog[idx];
        end
        return idle;
    endfunction

    function automatic int delay_for(input lc3b_word pc);
        int idx;
        idx = int'(pc) / `LC3B_PC_STEP;
        return (idx < num_rows) ? fetch_delay[idx] : 0;
    endfunction

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            stop_on_failure();
        end
    endtask

    initial begin
        int unsigned seed;
        int          row;
        int          head;
        int          k;
        int          seq;
        int          cycle_count;
        int          cycle_limit;
        logic        redirect_seen;
        logic        fetch_seen;
        lc3b_word    redirect_target;
        lc3b_word    pc_seen;
        access_t     next_access;

        i_reset       = 1'b1;
        i_imem_resp   = 1'b0;
        i_dmem_resp   = 1'b0;
        i_br_enable   = 1'b0;
        i_fetch_op    = op_br;
        i_fetch_nzp   = 3'b000;
        i_redirect_pc = '0;
        seed          = 98210;
        void'($urandom(seed));
        for (row = 0; row < num_rows; row++) begin
            fetch_delay[row] = $urandom % (max_delay + 1);
            data_delay[row]  = $urandom % (max_delay + 1);
        end

        // walk the program in retirement order
        row = 0;
        seq = 0;
        while (row < num_rows) begin
            retire_q.push_back(row);
            for (k = 0; k < data_accesses(prog[row].op); k++) begin
                next_access.seq   = seq;
                next_access.delay = data_delay[row];
                next_access.write = writes_data(prog[row].op, k);
                data_q.push_back(next_access);
            end
            seq++;
            if (transfers_control(prog[row].op) || prog[row].taken) begin
                row = prog[row].target;
            end else begin
                row++;
            end
        end
        cycle_limit = num_rows * (5 + 2 * max_delay) + 50;

        repeat (2) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        check_value("o_pc", o_pc, `LC3B_RESET_PC);
        check_value("o_dmem_read", o_dmem_read, 1'b0);
        check_value("o_dmem_write", o_dmem_write, 1'b0);
        check_value("o_imem_read", o_imem_read, 1'b1);
        pc_seen       = o_pc;
        req_pc        = o_pc;
        redirect_seen = 1'b0;
        fetch_seen    = 1'b0;
        fetch_wait    = 0;
        data_wait     = 0;
        retired_count = 0;
        jump_pending  = 1'b0;
        cycle_count   = 0;

        while (retire_q.size() > 0) begin
            head = retire_q[0];
            // PC movement over the last clock edge
            if (redirect_seen) begin
                check_value("o_pc", o_pc, redirect_target);
            end else if (o_pc != pc_seen) begin
                check_value("o_pc", o_pc, pc_seen + lc3b_word'(`LC3B_PC_STEP));
                check_value("i_imem_resp", fetch_seen, 1'b1);
                fetch_q.push_back(pc_seen);
                if (transfers_control(row_at(pc_seen).op)) begin
                    jump_pending = 1'b1;
                end
            end

            i_br_enable   = prog[head].taken;
            i_redirect_pc = lc3b_word'(`LC3B_PC_STEP * prog[head].target);
            if (o_pc != req_pc) begin
                req_pc     = o_pc;
                fetch_wait = 0;
            end
            i_imem_resp = (fetch_wait >= delay_for(o_pc));
            i_fetch_op  = row_at(o_pc).op;
            i_fetch_nzp = row_at(o_pc).nzp;
            i_dmem_resp = (o_dmem_read || o_dmem_write) && (data_q.size() > 0) &&
                          (data_wait >= data_q[0].delay);

            // settled values ahead of the rising edge
            #3;
            fetch_seen      = i_imem_resp && o_imem_read;
            redirect_seen   = o_flush || (o_wb_valid && transfers_control(prog[head].op));
            redirect_target = i_redirect_pc;
            pc_seen         = o_pc;
            if (o_imem_read && !i_imem_resp) begin
                fetch_wait++;
            end
            if (jump_pending) begin
                check_value("o_imem_read", o_imem_read, 1'b0);
            end
            if (o_flush) begin
                check_value("o_flush", o_flush, prog[head].taken);
            end
            if (o_wb_valid) begin
                check_value("o_wb_op", o_wb_op, prog[head].op);
                check_value("o_flush", o_flush, prog[head].taken);
                // every access of the retiring instruction was answered
                if (data_q.size() > 0) begin
                    check_value("data responses owed", data_q[0].seq == retired_count, 1'b0);
                end
                if (fetch_q.size() == 0) begin
                    $display("an instruction retired that was never fetched");
                    stop_on_failure();
                end else begin
                    check_value("retired pc", fetch_q.pop_front(), `LC3B_PC_STEP * head);
                end
                // whatever was fetched behind a taken branch is wrong path
                if (prog[head].taken) begin
                    fetch_q.delete();
                end
                if (transfers_control(prog[head].op)) begin
                    jump_pending = 1'b0;
                end
                retired_count++;
                void'(retire_q.pop_front());
            end
            if (o_dmem_read || o_dmem_write) begin
                if (i_dmem_resp) begin
                    check_value("o_dmem_write", o_dmem_write, data_q[0].write);
                    check_value("o_dmem_read", o_dmem_read, !data_q[0].write);
                    data_wait = 0;
                    void'(data_q.pop_front());
                end else begin
                    data_wait++;
                end
            end else begin
                data_wait = 0;
            end

            @(negedge clk);
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("timed out after %0d cycles with %0d instructions not retired",
                         cycle_count, retire_q.size());
                stop_on_failure();
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- common/lc3b_defines.svh
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// instruction fields kept by the control model
`define LC3B_OP_WIDTH   4
`define LC3B_NZP_WIDTH  3

// byte-addressed program counter
`define LC3B_PC_WIDTH   16
`define LC3B_RESET_PC   16'h0000

// distance between two consecutive instruction words
`define LC3B_PC_STEP    2

`endif

//--- common/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    `include "lc3b_defines.svh"

    typedef logic [`LC3B_PC_WIDTH-1:0] lc3b_word;

    // branch condition mask, 000 never taken
    typedef logic [`LC3B_NZP_WIDTH-1:0] lc3b_nzp;

    typedef enum logic [`LC3B_OP_WIDTH-1:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // one pipeline slot, all zero reads as a br with nzp 000
    typedef struct packed {
        logic       valid;
        lc3b_opcode op;
        lc3b_nzp    nzp;
        lc3b_word   pc;
    } stage_info_t;

    // LDI/STI between first and second data access
    typedef struct packed {
        logic       active;
        lc3b_opcode op;
    } inter_info_t;

endpackage

`default_nettype wire

//--- filelist.f
+incdir+common
common/lc3b_pkg.sv
src/fetch_unit.sv
pipeline/stage_reg.sv
pipeline/pipe_track.sv
src/hazard_detection.sv
src/pipe_ctrl_top.sv
bench/tb_pipe_ctrl.sv

//--- pipeline/pipe_track.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_track (
    input  wire logic                 clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_load,
    input  wire logic                 i_flush,
    input  wire logic                 i_fetch_valid,
    input  wire lc3b_pkg::lc3b_opcode i_fetch_op,
    input  wire lc3b_pkg::lc3b_nzp    i_fetch_nzp,
    input  wire lc3b_pkg::lc3b_word   i_fetch_pc,
    input  wire logic                 i_dmem_resp,
    output lc3b_pkg::lc3b_opcode      o_op_id,
    output lc3b_pkg::lc3b_opcode      o_op_ex,
    output lc3b_pkg::lc3b_opcode      o_op_mem,
    output lc3b_pkg::lc3b_opcode      o_op_mem_inter,
    output lc3b_pkg::lc3b_opcode      o_op_wb,
    output lc3b_pkg::lc3b_nzp         o_nzp_id,
    output lc3b_pkg::lc3b_nzp         o_nzp_ex,
    output lc3b_pkg::lc3b_nzp         o_nzp_mem,
    output lc3b_pkg::lc3b_nzp         o_nzp_wb,
    output logic                      o_dmem_read,
    output logic                      o_dmem_write,
    output logic                      o_inter_read,
    output logic                      o_inter_write,
    output logic                      o_wb_valid
);

    import lc3b_pkg::*;

    stage_info_t fetch_rec;
    stage_info_t if_id;
    stage_info_t id_ex;
    stage_info_t ex_mem;
    stage_info_t mem_wb;
    stage_info_t wb_d;
    inter_info_t inter_q;
    inter_info_t inter_d;
    logic        ind_mem;
    logic        first_resp;
    logic        second_resp;

    always_comb begin
        fetch_rec = '0;
        if (i_fetch_valid) begin
            fetch_rec.valid = 1'b1;
            fetch_rec.op    = i_fetch_op;
            fetch_rec.nzp   = i_fetch_nzp;
            fetch_rec.pc    = i_fetch_pc;
        end
    end

    // the slot leaving MEM is younger than a taken branch in WB
    assign wb_d = i_flush ? stage_info_t'('0) : ex_mem;

    stage_reg #(.T(stage_info_t)) u_if_id (
        .clk(clk), .i_reset(i_reset), .i_load(i_load), .i_flush(i_flush),
        .i_d(fetch_rec), .o_q(if_id)
    );

    stage_reg #(.T(stage_info_t)) u_id_ex (
        .clk(clk), .i_reset(i_reset), .i_load(i_load), .i_flush(i_flush),
        .i_d(if_id), .o_q(id_ex)
    );

    stage_reg #(.T(stage_info_t)) u_ex_mem (
        .clk(clk), .i_reset(i_reset), .i_load(i_load), .i_flush(i_flush),
        .i_d(id_ex), .o_q(ex_mem)
    );

    stage_reg #(.T(stage_info_t)) u_mem_wb (
        .clk(clk), .i_reset(i_reset), .i_load(i_load), .i_flush(1'b0),
        .i_d(wb_d), .o_q(mem_wb)
    );

    // indirect access, pointer first then data
    assign ind_mem     = ex_mem.valid && (ex_mem.op == op_ldi || ex_mem.op == op_sti);
    assign first_resp  = i_dmem_resp && ind_mem && !inter_q.active;
    assign second_resp = i_dmem_resp && inter_q.active;

    always_comb begin
        inter_d = '0;
        if (first_resp) begin
            inter_d.active = 1'b1;
            inter_d.op     = ex_mem.op;
        end
    end

    stage_reg #(.T(inter_info_t)) u_mem_inter (
        .clk(clk), .i_reset(i_reset), .i_load(first_resp || second_resp),
        .i_flush(i_flush), .i_d(inter_d), .o_q(inter_q)
    );

    always_comb begin
        o_dmem_read  = 1'b0;
        o_dmem_write = 1'b0;
        if (ex_mem.valid) begin
            case (ex_mem.op)
                op_ldr, op_ldb, op_ldi: o_dmem_read = 1'b1;
                op_str, op_stb:         o_dmem_write = 1'b1;
                // STI reads its pointer, then writes through it
                op_sti: begin
                    o_dmem_read  = !inter_q.active;
                    o_dmem_write = inter_q.active;
                end
                default: ;
            endcase
        end
    end

    assign o_inter_read  = inter_q.active && (inter_q.op == op_ldi);
    assign o_inter_write = inter_q.active && (inter_q.op == op_sti);

    assign o_op_id        = if_id.op;
    assign o_op_ex        = id_ex.op;
    assign o_op_mem       = ex_mem.op;
    assign o_op_mem_inter = inter_q.op;
    assign o_op_wb        = mem_wb.op;
    assign o_nzp_id       = if_id.nzp;
    assign o_nzp_ex       = id_ex.nzp;
    assign o_nzp_mem      = ex_mem.nzp;
    assign o_nzp_wb       = mem_wb.nzp;

    // retires on the cycle it leaves WB
    assign o_wb_valid = mem_wb.valid && i_load;

endmodule

`default_nettype wire

//--- pipeline/stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type T = logic
) (
    input  wire logic clk,
    input  wire logic i_reset,
    input  wire logic i_load,
    input  wire logic i_flush,
    input  wire T     i_d,
    output T          o_q
);

    // an all-zero slot carries a clear valid bit
    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            o_q <= '0;
        end else if (i_load) begin
            o_q <= i_d;
        end
    end

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "lc3b_defines.svh"

module fetch_unit (
    input  wire logic               clk,
    input  wire logic               i_reset,
    input  wire logic               i_load_pc,
    input  wire logic               i_redirect,
    input  wire lc3b_pkg::lc3b_word i_redirect_pc,
    output lc3b_pkg::lc3b_word      o_pc
);

    import lc3b_pkg::*;

    lc3b_word pc_q;
    lc3b_word pc_inc;
    lc3b_word pc_next;

    // sequential fetch, predicted not taken
    assign pc_inc = pc_q + lc3b_word'(`LC3B_PC_STEP);

    always_comb begin
        pc_next = pc_inc;
        // control instruction retiring in WB supplies the target
        if (i_redirect) begin
            pc_next = i_redirect_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc_q <= `LC3B_RESET_PC;
        end else if (i_load_pc) begin
            pc_q <= pc_next;
        end
    end

    // address of the instruction being requested
    assign o_pc = pc_q;

endmodule

`default_nettype wire

//--- src/hazard_detection.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_detection (
    input  wire logic                 i_br_enable,
    input  wire logic                 i_imem_resp,
    input  wire logic                 i_dmem_resp,
    input  wire logic                 i_dmem_read,
    input  wire logic                 i_dmem_write,
    input  wire logic                 i_inter_read,
    input  wire logic                 i_inter_write,
    input  wire lc3b_pkg::lc3b_opcode i_op_id,
    input  wire lc3b_pkg::lc3b_opcode i_op_ex,
    input  wire lc3b_pkg::lc3b_opcode i_op_mem,
    input  wire lc3b_pkg::lc3b_opcode i_op_mem_inter,
    input  wire lc3b_pkg::lc3b_opcode i_op_wb,
    input  wire lc3b_pkg::lc3b_nzp    i_nzp_id,
    input  wire lc3b_pkg::lc3b_nzp    i_nzp_ex,
    input  wire lc3b_pkg::lc3b_nzp    i_nzp_mem,
    input  wire lc3b_pkg::lc3b_nzp    i_nzp_wb,
    output logic                      o_load,
    output logic                      o_load_pc,
    output logic                      o_ctrl_at_wb,
    output logic                      o_flush,
    output logic                      o_imem_read
);

    import lc3b_pkg::*;

    logic mem_op;
    logic fetch_done;
    logic ind_mem;
    logic inter_done;
    logic taken_br_wb;
    logic br_at_wb;
    logic br_in_flight;
    logic stall;

    // unconditional control transfers
    function automatic logic is_jump(input lc3b_opcode op);
        return (op == op_jmp) || (op == op_jsr) || (op == op_trap);
    endfunction

    // a br with nzp 000 is a bubble or a no-op
    function automatic logic is_real_br(input lc3b_opcode op, input lc3b_nzp nzp);
        return (op == op_br) && (nzp != 3'b000);
    endfunction

    assign mem_op     = i_dmem_read | i_dmem_write;
    assign fetch_done = i_imem_resp & o_imem_read;
    assign ind_mem    = (i_op_mem == op_ldi) || (i_op_mem == op_sti);

    // second access of LDI/STI answered this cycle
    assign inter_done = i_dmem_resp &&
        (((i_op_mem_inter == op_ldi) && i_inter_read) ||
         ((i_op_mem_inter == op_sti) && i_inter_write));

    assign br_at_wb    = is_real_br(i_op_wb, i_nzp_wb);
    assign taken_br_wb = br_at_wb && i_br_enable;

    assign br_in_flight = is_real_br(i_op_id, i_nzp_id) ||
                          is_real_br(i_op_ex, i_nzp_ex) ||
                          is_real_br(i_op_mem, i_nzp_mem);

    assign o_ctrl_at_wb = taken_br_wb || is_jump(i_op_wb);

    // wrong-path slots behind a mispredicted branch
    assign o_flush = taken_br_wb;

    always_comb begin
        o_imem_read = 1'b1;
        // target unknown until the jump reaches WB
        if (is_jump(i_op_id) || is_jump(i_op_ex) || is_jump(i_op_mem)) begin
            o_imem_read = 1'b0;
        end
        // PC is being redirected this cycle
        if (o_ctrl_at_wb) begin
            o_imem_read = 1'b0;
        end
    end

    always_comb begin
        stall = 1'b0;

        // data access in MEM not answered yet
        if (mem_op && !i_dmem_resp) begin
            stall = 1'b1;
        end

        // LDI/STI keep MEM until the second access completes
        if (ind_mem && !inter_done) begin
            stall = 1'b1;
        end

        // hold a conditional branch together with its fall-through fetch
        // instead of letting a bubble slip in behind it
        if (br_in_flight && o_imem_read && !i_imem_resp && !mem_op && !br_at_wb) begin
            stall = 1'b1;
        end

        o_load    = !stall;
        o_load_pc = fetch_done && !stall;

        // redirect does not wait for the pipeline to move
        if (o_ctrl_at_wb) begin
            o_load_pc = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/pipe_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl_top (
    input  wire logic                 clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_imem_resp,
    input  wire lc3b_pkg::lc3b_opcode i_fetch_op,
    input  wire lc3b_pkg::lc3b_nzp    i_fetch_nzp,
    input  wire logic                 i_dmem_resp,
    input  wire logic                 i_br_enable,
    input  wire lc3b_pkg::lc3b_word   i_redirect_pc,
    output lc3b_pkg::lc3b_word        o_pc,
    output logic                      o_imem_read,
    output logic                      o_dmem_read,
    output logic                      o_dmem_write,
    output logic                      o_flush,
    output logic                      o_wb_valid,
    output lc3b_pkg::lc3b_opcode      o_wb_op
);

    import lc3b_pkg::*;

    logic       load;
    logic       load_pc;
    logic       ctrl_at_wb;
    logic       fetch_valid;
    logic       inter_read;
    logic       inter_write;
    lc3b_opcode op_id;
    lc3b_opcode op_ex;
    lc3b_opcode op_mem;
    lc3b_opcode op_mem_inter;
    lc3b_nzp    nzp_id;
    lc3b_nzp    nzp_ex;
    lc3b_nzp    nzp_mem;
    lc3b_nzp    nzp_wb;

    // a PC load outside a redirect means an instruction arrived
    assign fetch_valid = load_pc && !ctrl_at_wb;

    fetch_unit u_fetch (
        .clk(clk), .i_reset(i_reset), .i_load_pc(load_pc),
        .i_redirect(ctrl_at_wb), .i_redirect_pc(i_redirect_pc), .o_pc(o_pc)
    );

    pipe_track u_track (
        .clk(clk), .i_reset(i_reset), .i_load(load), .i_flush(o_flush),
        .i_fetch_valid(fetch_valid), .i_fetch_op(i_fetch_op),
        .i_fetch_nzp(i_fetch_nzp), .i_fetch_pc(o_pc), .i_dmem_resp(i_dmem_resp),
        .o_op_id(op_id), .o_op_ex(op_ex), .o_op_mem(op_mem),
        .o_op_mem_inter(op_mem_inter), .o_op_wb(o_wb_op),
        .o_nzp_id(nzp_id), .o_nzp_ex(nzp_ex), .o_nzp_mem(nzp_mem), .o_nzp_wb(nzp_wb),
        .o_dmem_read(o_dmem_read), .o_dmem_write(o_dmem_write),
        .o_inter_read(inter_read), .o_inter_write(inter_write), .o_wb_valid(o_wb_valid)
    );

    hazard_detection u_hazard (
        .i_br_enable(i_br_enable), .i_imem_resp(i_imem_resp), .i_dmem_resp(i_dmem_resp),
        .i_dmem_read(o_dmem_read), .i_dmem_write(o_dmem_write),
        .i_inter_read(inter_read), .i_inter_write(inter_write),
        .i_op_id(op_id), .i_op_ex(op_ex), .i_op_mem(op_mem),
        .i_op_mem_inter(op_mem_inter), .i_op_wb(o_wb_op),
        .i_nzp_id(nzp_id), .i_nzp_ex(nzp_ex), .i_nzp_mem(nzp_mem), .i_nzp_wb(nzp_wb),
        .o_load(load), .o_load_pc(load_pc), .o_ctrl_at_wb(ctrl_at_wb),
        .o_flush(o_flush), .o_imem_read(o_imem_read)
    );

endmodule

`default_nettype wire
